// ==== fetch_cases.txt ====
# name command a b c, values in hex
# br a=addr b=word, train a=branch b=target c=hit, reg a=select b=data
# exc a=address b=restart pc, run a=cycles b=random locks c=redirects expected
br_at_40 br 40 0f000000 0
br_at_120 br 120 0f000000 0
seq_fetch run 1e 0 0
train_hit train 40 100 1
exc_redirect exc 31 30 0
predict_taken run 28 0 1
ctx_kpdtr reg 2 0000a000 0
ctx_pdtr reg 1 0000b000 0
ctx_tidr reg 3 fffc0000 0
ctx_psr reg 0 000000a3 0
ctx_run run 14 0 0
back_pressure run 78 1 0
train_miss train 40 100 0
exc_invalid exc 41 40 0
untrained_run run 1e 1 0

// ==== compile.f ====
+incdir+.
fetch_pkg.sv
fetch_sysreg.sv
fetch_addr_queue.sv
branch_predictor.sv
fetch.sv
fetch_top.sv
fetch_asserts.sv
tb_fetch.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_fetch
FLIST ?= compile.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

SRCS := $(filter-out +%,$(shell cat $(FLIST))) fetch_settings.svh
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_fetch.sv ====
// Fetch front end testbench
`timescale 1ns/1ps
`include "fetch_settings.svh"

module tb_fetch;

	localparam logic [31:0] SEED = 32'h9e6d_30d8;

	logic iCLOCK;
	logic inRESET;
	logic reg_we;
	fetch_pkg::sysreg_sel_t reg_sel;
	fetch_pkg::addr_t reg_wdata;
	logic exc_event;
	logic exc_addr_set;
	fetch_pkg::addr_t exc_addr;
	logic fetch_req;
	logic mem_lock;
	fetch_pkg::fetch_req_t req;
	logic inst_valid;
	fetch_pkg::inst_t inst;
	fetch_pkg::mmu_flags_t mmu_flags;
	logic prev_lock;
	fetch_pkg::bp_result_t bp_result;
	logic bp_flush;
	logic fetch_stop;
	logic next_lock;
	fetch_pkg::fetch_out_t out;

	string case_name[$];
	string case_cmd[$];
	logic [31:0] case_a[$];
	logic [31:0] case_b[$];
	logic [31:0] case_c[$];
	string cur_name = "reset";
	int errors = 0;
	int words_seen = 0;
	int flush_count = 0;
	int cycle = 0;
	int watchdog_cycles = 0;
	logic rnd_mode = 1'b0;
	logic out_loaded = 1'b0;
	fetch_pkg::addr_t restart_pc = '0;
	fetch_pkg::addr_t exp_pc = `FETCH_RESET_PC;
	fetch_pkg::addr_t pend_addr[$];	// Memory requests in flight
	int pend_ready[$];
	fetch_pkg::fetch_req_t exp_q[$];
	fetch_pkg::inst_t branch_word[fetch_pkg::addr_t];
	logic btb_valid[8];
	fetch_pkg::addr_t btb_addr[8];
	fetch_pkg::addr_t btb_target[8];
	fetch_pkg::addr_t m_psr = '0;
	fetch_pkg::addr_t m_pdtr = '0;
	fetch_pkg::addr_t m_kpdtr = '0;
	fetch_pkg::addr_t m_tidr = '0;

	fetch_top UUT (.*);

	initial begin
		iCLOCK = 1'b0;
		forever #4 iCLOCK = ~iCLOCK;
	end

	function automatic fetch_pkg::inst_t mem_word(input fetch_pkg::addr_t a);
		if (branch_word.exists(a))
			return branch_word[a];
		return a ^ 32'h5a5a_0000;
	endfunction

	function automatic fetch_pkg::fetch_ctx_t expected_ctx();
		fetch_pkg::fetch_ctx_t c;
		c.mmumod = m_psr[1:0];
		c.mmups = m_psr[9:7];
		c.asid = m_tidr[31:18];
		c.kernel_access = (m_psr[6:5] == 2'b00);
		c.pdt = c.kernel_access ? m_kpdtr : m_pdtr;
		c.paging_ena = |m_psr[1:0];
		return c;
	endfunction

	function automatic logic btb_hit(input fetch_pkg::addr_t a);
		return btb_valid[a[4:2]] && (btb_addr[a[4:2]][31:2] == a[31:2]);
	endfunction

	task automatic compare_value(input string what, input logic [127:0] exp_v,
		input logic [127:0] act_v);
		if (exp_v !== act_v) begin
			errors++;
			$display("FAILED %s %s expected %h actual %h", cur_name, what, exp_v, act_v);
		end
	endtask

	// Memory model and scoreboard
	always @(posedge iCLOCK) begin
		fetch_pkg::fetch_req_t e;
		fetch_pkg::addr_t flush_target;
		logic taken;
		logic exp_flush;
		if (inRESET) begin
			cycle++;
			if (out_loaded && out.valid) begin
				if (exp_q.size() == 0) begin
					errors++;
					$display("%s: output word at pc %h has no request", cur_name, out.pc);
				end else begin
					e = exp_q.pop_front();
					words_seen++;
					compare_value("out.inst", mem_word(e.addr), out.inst);
					compare_value("out.pc", e.addr + 32'd4, out.pc);
					compare_value("out.mmu_flags", e.addr[13:2], out.mmu_flags);
					compare_value("out.kernel_access", e.ctx.kernel_access, out.kernel_access);
					compare_value("out.paging_ena", e.ctx.paging_ena, out.paging_ena);
					compare_value("out.predict", 1'b0, out.predict);
				end
			end
			out_loaded = !next_lock && !bp_flush && !exc_event;
			taken = inst_valid && !prev_lock && (pend_addr.size() > 0);	// Memory stalls on prev_lock
			exp_flush = taken && branch_word.exists(pend_addr[0]) && btb_hit(pend_addr[0]);
			flush_target = taken ? btb_target[pend_addr[0][4:2]] : exp_pc;
			compare_value("bp_flush", exp_flush, bp_flush);
			if (taken) begin
				void'(pend_addr.pop_front());
				void'(pend_ready.pop_front());
			end
			if (fetch_req) begin
				compare_value("req.addr", exp_pc, req.addr);
				compare_value("req.ctx", expected_ctx(), req.ctx);
				pend_addr.push_back(exp_pc);
				pend_ready.push_back(cycle + int'($urandom_range(1, 3)));
				exp_q.push_back({exp_pc, expected_ctx()});
				exp_pc = exp_pc + 32'd4;
			end
			if (bp_flush || exc_event) begin
				pend_addr.delete();
				pend_ready.delete();
				exp_q.delete();
			end
			if (bp_flush) begin
				flush_count++;
				exp_pc = flush_target;
			end
			if (exc_addr_set)
				exp_pc = restart_pc;
			if (bp_result.jump && bp_result.hit) begin
				btb_valid[bp_result.inst_addr[4:2]] = 1'b1;
				btb_addr[bp_result.inst_addr[4:2]] = bp_result.inst_addr;
				btb_target[bp_result.inst_addr[4:2]] = bp_result.jump_addr;
			end else if (bp_result.jump && btb_hit(bp_result.inst_addr)) begin
				btb_valid[bp_result.inst_addr[4:2]] = 1'b0;
			end
			if (reg_we) begin
				case (reg_sel)
					fetch_pkg::PSR: m_psr = reg_wdata;
					fetch_pkg::PDTR: m_pdtr = reg_wdata;
					fetch_pkg::KPDTR: m_kpdtr = reg_wdata;
					default: m_tidr = reg_wdata;
				endcase
			end
			inst_valid <= (pend_addr.size() > 0) && (pend_ready[0] <= cycle);
			if (pend_addr.size() > 0) begin
				inst <= mem_word(pend_addr[0]);
				mmu_flags <= pend_addr[0][13:2];
			end
			next_lock <= rnd_mode && ($urandom_range(0, 3) == 0);
			mem_lock <= rnd_mode && ($urandom_range(0, 3) == 0);
			fetch_stop <= rnd_mode && ($urandom_range(0, 7) == 0);
		end
	end

	initial begin
		wait (watchdog_cycles > 0);
		repeat (watchdog_cycles) @(posedge iCLOCK);
		$display("watchdog expired after %0d cycles", watchdog_cycles);
		$display("sim failed");
		$finish;
	end

	initial begin
		int fd;
		int n;
		int total_run;
		int base;
		string name;
		string cmd;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [8*256-1:0] skip_line;
		void'($urandom(SEED));
		inRESET = 1'b0;
		reg_we = 1'b0;
		reg_sel = fetch_pkg::PSR;
		reg_wdata = '0;
		exc_event = 1'b0;
		exc_addr_set = 1'b0;
		exc_addr = '0;
		mem_lock = 1'b0;
		inst_valid = 1'b0;
		inst = '0;
		mmu_flags = '0;
		bp_result = '0;
		fetch_stop = 1'b0;
		next_lock = 1'b0;
		total_run = 0;
		foreach (btb_valid[i])
			btb_valid[i] = 1'b0;
		fd = $fopen("fetch_cases.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("cannot open case file fetch_cases.txt");
		end else begin
			while (!$feof(fd)) begin
				n = $fscanf(fd, "%s", name);
				if (n == 1 && name.substr(0, 0) == "#") begin
					n = $fgets(skip_line, fd);	// Column description
				end else if (n == 1) begin
					n = $fscanf(fd, "%s %h %h %h", cmd, a, b, c);
					if (n != 4) begin
						errors++;
						$display("case record %s is incomplete", name);
					end
					case_name.push_back(name);
					case_cmd.push_back(cmd);
					case_a.push_back(a);
					case_b.push_back(b);
					case_c.push_back(c);
					if (cmd == "run")
						total_run += int'(a);
				end
			end
			$fclose(fd);
		end
		watchdog_cycles = total_run * 20;
		repeat (5) @(posedge iCLOCK);
		inRESET <= 1'b1;
		foreach (case_name[i]) begin
			cur_name = case_name[i];
			case (case_cmd[i])
				"br": branch_word[case_a[i]] = case_b[i];
				"reg": begin
					@(posedge iCLOCK);
					reg_we <= 1'b1;
					reg_sel <= fetch_pkg::sysreg_sel_t'(case_a[i][1:0]);
					reg_wdata <= case_b[i];
					@(posedge iCLOCK);
					reg_we <= 1'b0;
				end
				"train": begin
					@(posedge iCLOCK);
					bp_result <= {1'b1, case_c[i][0], case_b[i], case_a[i]};
					@(posedge iCLOCK);
					bp_result <= '0;	// Strobe lasts one cycle
				end
				"exc": begin
					@(posedge iCLOCK);
					exc_event <= 1'b1;
					@(posedge iCLOCK);
					exc_event <= 1'b0;
					exc_addr_set <= 1'b1;
					exc_addr <= case_a[i];
					restart_pc <= case_b[i];
					@(posedge iCLOCK);
					exc_addr_set <= 1'b0;
				end
				"run": begin
					@(negedge iCLOCK);
					base = flush_count;
					@(posedge iCLOCK);
					rnd_mode <= case_b[i][0];
					repeat (case_a[i]) @(posedge iCLOCK);
					rnd_mode <= 1'b0;
					@(negedge iCLOCK);
					compare_value("redirects", case_c[i], flush_count - base);
				end
				default: begin
					errors++;
					$display("%s: unknown command %s", case_name[i], case_cmd[i]);
				end
			endcase
		end
		repeat (10) @(posedge iCLOCK);
		if (words_seen == 0) begin
			errors++;
			$display("no instruction reached the decode output");
		end
		$display("checked %0d output words, %0d errors, %0d assertion failures", words_seen,
			errors, UUT.u_asserts.fail_count);
		if (errors == 0 && UUT.u_asserts.fail_count == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// ==== fetch_asserts.sv ====
// Fetch front end assertions
`timescale 1ns/1ps

module fetch_asserts (
	input logic iCLOCK,
	input logic inRESET,
	input logic exc_event,
	input logic fetch_req,
	input logic next_lock,
	input logic bp_flush,
	input fetch_pkg::fetch_out_t out
);

	int fail_count = 0;	// Failed assertions so far

	a_no_req_exc: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		exc_event |-> !fetch_req) else begin
		$error("fetch request issued during exception");
		fail_count++;
	end

	// Exception flush overrides the decode stall
	a_out_hold: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		next_lock && !exc_event |=> $stable(out)) else begin
		$error("output changed under lock");
		fail_count++;
	end

	a_flush_no_req: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		bp_flush |-> !fetch_req) else begin
		$error("fetch request issued during redirect");
		fail_count++;
	end

	a_flush_clears: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		bp_flush || exc_event |=> !out.valid) else begin
		$error("output valid after flush");
		fail_count++;
	end

endmodule

bind fetch_top fetch_asserts u_asserts (
	.iCLOCK(iCLOCK),
	.inRESET(inRESET),
	.exc_event(exc_event),
	.fetch_req(fetch_req),
	.next_lock(next_lock),
	.bp_flush(bp_flush),
	.out(out)
);

// ==== fetch_top.sv ====
// Fetch front end top level
`timescale 1ns/1ps

module fetch_top (
	input logic iCLOCK,
	input logic inRESET,
	input logic reg_we,
	input fetch_pkg::sysreg_sel_t reg_sel,
	input fetch_pkg::addr_t reg_wdata,
	input logic exc_event,
	input logic exc_addr_set,
	input fetch_pkg::addr_t exc_addr,
	output logic fetch_req,
	input logic mem_lock,
	output fetch_pkg::fetch_req_t req,
	input logic inst_valid,
	input fetch_pkg::inst_t inst,
	input fetch_pkg::mmu_flags_t mmu_flags,
	output logic prev_lock,
	input fetch_pkg::bp_result_t bp_result,
	output logic bp_flush,
	input logic fetch_stop,
	input logic next_lock,
	output fetch_pkg::fetch_out_t out
);

	fetch_pkg::fetch_ctx_t ctx;

	fetch_sysreg u_sysreg (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.reg_we(reg_we),
		.reg_sel(reg_sel),
		.reg_wdata(reg_wdata),
		.ctx(ctx)
	);

	fetch u_fetch (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.ctx(ctx),
		.exc_event(exc_event),
		.exc_addr_set(exc_addr_set),
		.exc_addr(exc_addr),
		.fetch_req(fetch_req),
		.mem_lock(mem_lock),
		.req(req),
		.inst_valid(inst_valid),
		.inst(inst),
		.mmu_flags(mmu_flags),
		.prev_lock(prev_lock),
		.bp_result(bp_result),
		.bp_flush(bp_flush),
		.fetch_stop(fetch_stop),
		.next_lock(next_lock),
		.out(out)
	);

endmodule

// ==== fetch.sv ====
// Instruction fetch unit
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch (
	input logic iCLOCK,
	input logic inRESET,
	input fetch_pkg::fetch_ctx_t ctx,
	input logic exc_event,
	input logic exc_addr_set,
	input fetch_pkg::addr_t exc_addr,
	output logic fetch_req,
	input logic mem_lock,
	output fetch_pkg::fetch_req_t req,
	input logic inst_valid,
	input fetch_pkg::inst_t inst,
	input fetch_pkg::mmu_flags_t mmu_flags,
	output logic prev_lock,
	input fetch_pkg::bp_result_t bp_result,
	output logic bp_flush,
	input logic fetch_stop,
	input logic next_lock,
	output fetch_pkg::fetch_out_t out
);

	fetch_pkg::fetch_state_t state;
	fetch_pkg::addr_t pc;
	fetch_pkg::fetch_req_t q_head;
	fetch_pkg::addr_t predict_addr;
	fetch_pkg::fetch_out_t out_r;
	logic q_full;
	logic issue;
	logic front_flush;
	logic search_stb;
	logic predict;
	logic take;

	function automatic logic is_branch(input fetch_pkg::inst_t word);
		case (word[30:21])
			`FETCH_OC_B,
			`FETCH_OC_BR,
			`FETCH_OC_BUR: is_branch = 1'b1;
			default: is_branch = 1'b0;
		endcase
	endfunction

	// One issue condition, shared by the request and the queue write
	assign issue = (state == fetch_pkg::FETCHING) && !exc_event && !bp_flush &&
		!q_full && !mem_lock && !fetch_stop;
	assign front_flush = exc_event || bp_flush;
	assign take = inst_valid && !next_lock;	// Word leaves the memory this cycle

	assign fetch_req = issue;
	assign req.addr = pc;
	assign req.ctx = ctx;
	assign prev_lock = next_lock;

	fetch_addr_queue u_queue (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.flush(front_flush),
		.wr_en(issue),
		.wr_data(req),
		.full(q_full),
		.rd_en(take),
		.rd_data(q_head)
	);

	assign search_stb = inst_valid && is_branch(inst);

	branch_predictor u_btb (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.flush(1'b0),
		.search_stb(search_stb),
		.search_addr(q_head.addr),
		.predict(predict),
		.predict_addr(predict_addr),
		.train(bp_result)
	);

	assign bp_flush = !next_lock && predict;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= fetch_pkg::RESET_START;
			pc <= `FETCH_RESET_PC;
		end else if (exc_addr_set) begin
			state <= fetch_pkg::FETCHING;
			pc <= {exc_addr[31:1], 1'b0};	// Halfword aligned restart
		end else if (exc_event) begin
			state <= fetch_pkg::WAIT_ADDR;
		end else if (bp_flush) begin
			state <= fetch_pkg::FETCHING;
			pc <= predict_addr;
		end else begin
			case (state)
				fetch_pkg::RESET_START: begin
					state <= fetch_pkg::FETCHING;
					pc <= `FETCH_RESET_PC;
				end
				fetch_pkg::FETCHING: begin
					if (issue) begin
						pc <= pc + `FETCH_PC_STEP;
					end
				end
				default: state <= state;	// Waiting for a restart address
			endcase
		end
	end

	// Decode output register
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			out_r <= '0;
		end else if (front_flush) begin
			out_r <= '0;
		end else if (!next_lock) begin
			out_r.valid <= inst_valid;
			out_r.inst <= inst;
			out_r.pc <= q_head.addr + `FETCH_PC_STEP;
			out_r.mmu_flags <= mmu_flags;
			out_r.paging_ena <= q_head.ctx.paging_ena;
			out_r.kernel_access <= q_head.ctx.kernel_access;
			out_r.predict <= predict;
			out_r.predict_addr <= predict_addr;
		end
	end

	assign out = out_r;

endmodule

// ==== branch_predictor.sv ====
// Branch target buffer
`timescale 1ns/1ps
`include "fetch_settings.svh"

module branch_predictor (
	input logic iCLOCK,
	input logic inRESET,
	input logic flush,
	input logic search_stb,
	input fetch_pkg::addr_t search_addr,
	output logic predict,
	output fetch_pkg::addr_t predict_addr,
	input fetch_pkg::bp_result_t train
);

	localparam int ENTRIES = `FETCH_BTB_ENTRIES;
	localparam int IW = $clog2(ENTRIES);
	localparam int TW = 32 - IW - 2;

	typedef logic [IW-1:0] btb_idx_t;
	typedef logic [TW-1:0] btb_tag_t;

	logic [ENTRIES-1:0] entry_valid;
	btb_tag_t entry_tag [ENTRIES];
	fetch_pkg::addr_t entry_target [ENTRIES];

	btb_idx_t search_idx;
	btb_tag_t search_tag;
	btb_idx_t train_idx;
	btb_tag_t train_tag;
	logic train_match;

	// Tag is everything above the index, byte bits dropped
	assign search_idx = search_addr[IW+1:2];
	assign search_tag = search_addr[31:IW+2];
	assign train_idx = train.inst_addr[IW+1:2];
	assign train_tag = train.inst_addr[31:IW+2];

	assign predict = search_stb && entry_valid[search_idx] &&
		(entry_tag[search_idx] == search_tag);
	assign predict_addr = entry_target[search_idx];

	assign train_match = entry_valid[train_idx] && (entry_tag[train_idx] == train_tag);

	// Tags and targets are only meaningful behind a valid bit
	always_ff @(posedge iCLOCK) begin
		if (train.jump && train.hit) begin
			entry_tag[train_idx] <= train_tag;
			entry_target[train_idx] <= train.jump_addr;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			entry_valid <= '0;
		end else if (flush) begin
			entry_valid <= '0;
		end else if (train.jump) begin
			if (train.hit) begin
				entry_valid[train_idx] <= 1'b1;
			end else if (train_match) begin
				entry_valid[train_idx] <= 1'b0;	// Mispredicted, forget it
			end
		end
	end

endmodule

// ==== fetch_addr_queue.sv ====
// Fetch request queue
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_addr_queue #(
	parameter int DEPTH = `FETCH_QUEUE_DEPTH,
	parameter int AW = `FETCH_QUEUE_AW
) (
	input logic iCLOCK,
	input logic inRESET,
	input logic flush,
	input logic wr_en,
	input fetch_pkg::fetch_req_t wr_data,
	output logic full,
	input logic rd_en,
	output fetch_pkg::fetch_req_t rd_data
);

	localparam logic [AW:0] FULL_COUNT = (AW + 1)'(DEPTH);

	fetch_pkg::fetch_req_t mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0] count;
	logic do_wr;
	logic do_rd;

	assign full = (count == FULL_COUNT);
	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && (count != '0);	// Empty reads are ignored

	// Show-ahead, head word always visible
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge iCLOCK) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;	// Both or neither
			endcase
		end
	end

endmodule

// ==== fetch_sysreg.sv ====
// System registers and fetch context
`timescale 1ns/1ps

module fetch_sysreg (
	input logic iCLOCK,
	input logic inRESET,
	input logic reg_we,
	input fetch_pkg::sysreg_sel_t reg_sel,
	input fetch_pkg::addr_t reg_wdata,
	output fetch_pkg::fetch_ctx_t ctx
);

	fetch_pkg::addr_t psr;
	fetch_pkg::addr_t pdtr;
	fetch_pkg::addr_t kpdtr;
	fetch_pkg::addr_t tidr;
	logic kernel_mode;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			psr <= '0;
			pdtr <= '0;
			kpdtr <= '0;
			tidr <= '0;
		end else if (reg_we) begin
			case (reg_sel)
				fetch_pkg::PSR: psr <= reg_wdata;
				fetch_pkg::PDTR: pdtr <= reg_wdata;
				fetch_pkg::KPDTR: kpdtr <= reg_wdata;
				fetch_pkg::TIDR: tidr <= reg_wdata;
				default: psr <= psr;
			endcase
		end
	end

	// Privilege level zero is kernel
	assign kernel_mode = (psr[6:5] == 2'b00);

	always_comb begin
		ctx.mmumod = psr[1:0];
		ctx.mmups = psr[9:7];
		ctx.asid = tidr[31:18];
		ctx.pdt = kernel_mode ? kpdtr : pdtr;	// Kernel uses its own table
		ctx.kernel_access = kernel_mode;
		ctx.paging_ena = |psr[1:0];
	end

endmodule

// ==== fetch_pkg.sv ====
// Fetch front end types

package fetch_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] inst_t;
	typedef logic [11:0] mmu_flags_t;
	typedef logic [13:0] asid_t;

	typedef enum logic [1:0] {
		PSR,
		PDTR,
		KPDTR,
		TIDR
	} sysreg_sel_t;

	typedef enum logic [1:0] {
		RESET_START,
		FETCHING,
		WAIT_ADDR
	} fetch_state_t;

	// Context that travels with every request
	typedef struct packed {
		logic [1:0] mmumod;
		logic [2:0] mmups;
		asid_t asid;
		addr_t pdt;
		logic kernel_access;
		logic paging_ena;
	} fetch_ctx_t;

	typedef struct packed {
		addr_t addr;
		fetch_ctx_t ctx;
	} fetch_req_t;

	// Branch resolution feedback
	typedef struct packed {
		logic jump;
		logic hit;
		addr_t jump_addr;
		addr_t inst_addr;
	} bp_result_t;

	typedef struct packed {
		logic valid;
		inst_t inst;
		addr_t pc;
		mmu_flags_t mmu_flags;
		logic paging_ena;
		logic kernel_access;
		logic predict;
		addr_t predict_addr;
	} fetch_out_t;

endpackage

// ==== fetch_settings.svh ====
// Fetch front end settings

`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// Request queue, entries in flight and pointer width
`define FETCH_QUEUE_DEPTH 8
`define FETCH_QUEUE_AW 3

// Branch target buffer, indexed by address bits 4 to 2
`define FETCH_BTB_ENTRIES 8

// Branch opcodes found in instruction bits 30 to 21
`define FETCH_OC_B 10'h078
`define FETCH_OC_BR 10'h079
`define FETCH_OC_BUR 10'h07a

// First fetch address after reset
`define FETCH_RESET_PC 32'h0000_0000

// Single instruction per step
`define FETCH_PC_STEP 32'd4

`endif
